//--- status_console_pkg.sv
package status_console_pkg;

   // --------------------
   // Widths with a meaning
   typedef logic [7:0]  char_t;
   typedef logic [9:0]  scr_addr_t;   // {row[4:0], col[4:0]}
   typedef logic [6:0]  rom_addr_t;
   typedef logic [3:0]  nibble_t;
   typedef logic [56:0] dna_t;
   typedef logic [7:0]  joy_t;        // up down left right b1 b2 b3 start

   typedef struct packed {
      logic      we;
      scr_addr_t addr;
      char_t     data;
   } scr_wr_t;

   // --------------------
   // Screen and control codes
   localparam int scr_cols = 32;
   localparam int scr_rows = 19;

   localparam char_t code_at  = 8'd22;   // followed by row, col
   localparam char_t code_end = 8'hff;

   // Joystick letters, up first
   localparam logic [63:0] joy_names = "UDLR123S";

   // --------------------
   // Message ROM offsets
   localparam rom_addr_t msg_vga    = 7'd0;
   localparam rom_addr_t msg_pal    = 7'd8;
   localparam rom_addr_t msg_ntsc   = 7'd16;
   localparam rom_addr_t msg_at_dna = 7'd24;
   localparam rom_addr_t msg_at_mem = 7'd28;
   localparam rom_addr_t msg_at_joy = 7'd32;
   localparam rom_addr_t msg_ok     = 7'd36;
   localparam rom_addr_t msg_error  = 7'd42;
   localparam rom_addr_t msg_wait   = 7'd48;

   typedef enum logic [3:0] {
      s_video, s_dna, s_dna_digit, s_mem, s_mem_status, s_joy, s_joy_bit,
      s_str_fetch, s_str_check, s_send, s_send_wait
   } seq_state_t;

   typedef enum logic [2:0] {
      tty_idle, tty_command, tty_at_row, tty_at_col, tty_put
   } tty_state_t;

endpackage

//--- message_rom.sv
module message_rom import status_console_pkg::*; (
   input  logic      clk,
   input  rom_addr_t rom_addr,
   output char_t     rom_data
);

   // Unlisted addresses read as code_end, which also terminates every string
   always_ff @(posedge clk) begin
      case (rom_addr)
         // --------------------
         // Video mode, row 3 col 10
         msg_vga:             rom_data <= code_at;
         msg_vga + 7'd1:      rom_data <= 8'd3;
         msg_vga + 7'd2:      rom_data <= 8'd10;
         msg_vga + 7'd3:      rom_data <= "V";
         msg_vga + 7'd4:      rom_data <= "G";
         msg_vga + 7'd5:      rom_data <= "A";
         msg_vga + 7'd6:      rom_data <= " ";

         msg_pal:             rom_data <= code_at;
         msg_pal + 7'd1:      rom_data <= 8'd3;
         msg_pal + 7'd2:      rom_data <= 8'd10;
         msg_pal + 7'd3:      rom_data <= "P";
         msg_pal + 7'd4:      rom_data <= "A";
         msg_pal + 7'd5:      rom_data <= "L";
         msg_pal + 7'd6:      rom_data <= " ";

         msg_ntsc:            rom_data <= code_at;
         msg_ntsc + 7'd1:     rom_data <= 8'd3;
         msg_ntsc + 7'd2:     rom_data <= 8'd10;
         msg_ntsc + 7'd3:     rom_data <= "N";
         msg_ntsc + 7'd4:     rom_data <= "T";
         msg_ntsc + 7'd5:     rom_data <= "S";
         msg_ntsc + 7'd6:     rom_data <= "C";

         // --------------------
         // Cursor positions only
         msg_at_dna:          rom_data <= code_at;
         msg_at_dna + 7'd1:   rom_data <= 8'd4;
         msg_at_dna + 7'd2:   rom_data <= 8'd10;

         msg_at_mem:          rom_data <= code_at;
         msg_at_mem + 7'd1:   rom_data <= 8'd6;
         msg_at_mem + 7'd2:   rom_data <= 8'd21;

         msg_at_joy:          rom_data <= code_at;
         msg_at_joy + 7'd1:   rom_data <= 8'd7;
         msg_at_joy + 7'd2:   rom_data <= 8'd21;

         // --------------------
         // Status words, five wide
         msg_ok:              rom_data <= "O";
         msg_ok + 7'd1:       rom_data <= "K";
         msg_ok + 7'd2:       rom_data <= " ";
         msg_ok + 7'd3:       rom_data <= " ";
         msg_ok + 7'd4:       rom_data <= " ";

         msg_error:           rom_data <= "E";
         msg_error + 7'd1:    rom_data <= "R";
         msg_error + 7'd2:    rom_data <= "R";
         msg_error + 7'd3:    rom_data <= "O";
         msg_error + 7'd4:    rom_data <= "R";

         msg_wait:            rom_data <= "w";
         msg_wait + 7'd1:     rom_data <= "a";
         msg_wait + 7'd2:     rom_data <= "i";
         msg_wait + 7'd3:     rom_data <= "t";
         msg_wait + 7'd4:     rom_data <= " ";

         default:             rom_data <= code_end;
      endcase
   end

endmodule

//--- status_sequencer.sv
module status_sequencer import status_console_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      vga,
   input  logic      ntsc,
   input  dna_t      dna,
   input  logic      mem_progress,
   input  logic      mem_ok,
   input  joy_t      joy,
   output rom_addr_t rom_addr,
   input  char_t     rom_data,
   output char_t     chr,
   output logic      chr_we,
   input  logic      busy
);

   seq_state_t  state;
   seq_state_t  ret_str;     // resume point after a ROM string
   seq_state_t  ret_chr;     // resume point after one character
   logic [3:0]  cnt;         // digit or joystick bit index
   logic [59:0] dna_sr;
   joy_t        joy_sr;

   function automatic char_t hex_char(input nibble_t n);
      if (n < 4'd10)
         return 8'h30 + {4'h0, n};
      else
         return 8'h37 + {4'h0, n};   // 'A' - 10
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= s_video;
         ret_str  <= s_video;
         ret_chr  <= s_video;
         cnt      <= 4'd0;
         rom_addr <= msg_vga;
         chr_we   <= 1'b0;
      end else begin
         case (state)
            // --------------------
            // Report lines
            s_video: begin
               if (vga)
                  rom_addr <= msg_vga;
               else if (!ntsc)
                  rom_addr <= msg_pal;
               else
                  rom_addr <= msg_ntsc;
               ret_str <= s_dna;
               state   <= s_str_fetch;
            end

            s_dna: begin
               rom_addr <= msg_at_dna;
               dna_sr   <= {3'b000, dna};
               cnt      <= 4'd0;
               ret_str  <= s_dna_digit;
               state    <= s_str_fetch;
            end

            s_dna_digit: begin
               if (cnt == 4'd15) begin
                  state <= s_mem;
               end else begin
                  chr     <= hex_char(dna_sr[59:56]);
                  dna_sr  <= {dna_sr[55:0], 4'h0};   // next digit up
                  cnt     <= cnt + 4'd1;
                  ret_chr <= s_dna_digit;
                  state   <= s_send;
               end
            end

            s_mem: begin
               rom_addr <= msg_at_mem;
               ret_str  <= s_mem_status;
               state    <= s_str_fetch;
            end

            s_mem_status: begin
               if (mem_progress)
                  rom_addr <= msg_wait;
               else if (mem_ok)
                  rom_addr <= msg_ok;
               else
                  rom_addr <= msg_error;
               ret_str <= s_joy;
               state   <= s_str_fetch;
            end

            s_joy: begin
               rom_addr <= msg_at_joy;
               joy_sr   <= joy;
               cnt      <= 4'd0;
               ret_str  <= s_joy_bit;
               state    <= s_str_fetch;
            end

            s_joy_bit: begin
               if (cnt == 4'd8) begin
                  state <= s_video;   // pass done, start over
               end else begin
                  chr     <= joy_sr[7] ? joy_names[8 * (7 - cnt[2:0]) +: 8] : 8'h20;
                  joy_sr  <= {joy_sr[6:0], 1'b0};
                  cnt     <= cnt + 4'd1;
                  ret_chr <= s_joy_bit;
                  state   <= s_send;
               end
            end

            // --------------------
            // String fetch, ROM data valid one cycle after the address
            s_str_fetch: begin
               rom_addr <= rom_addr + 7'd1;
               state    <= s_str_check;
            end

            s_str_check: begin
               if (rom_data == code_end) begin
                  state <= ret_str;
               end else begin
                  chr     <= rom_data;
                  ret_chr <= s_str_fetch;
                  state   <= s_send;
               end
            end

            // --------------------
            // Character handoff to the teletype
            s_send: begin
               if (!busy) begin
                  chr_we <= 1'b1;
                  state  <= s_send_wait;
               end
            end

            s_send_wait: begin
               chr_we <= 1'b0;   // busy not valid yet
               state  <= ret_chr;
            end

            default: state <= s_video;
         endcase
      end
   end

endmodule

//--- teletype.sv
module teletype import status_console_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  char_t   chr,
   input  logic    chr_we,
   output logic    busy,
   output scr_wr_t scr_wr
);

   tty_state_t state;
   scr_addr_t  cursor;
   char_t      data;       // byte latched in idle
   logic [4:0] row;        // pending row of a position command

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= tty_idle;
         busy      <= 1'b0;
         cursor    <= '0;
         scr_wr.we <= 1'b0;
      end else begin
         case (state)
            tty_idle: begin
               if (chr_we) begin
                  data  <= chr;
                  busy  <= 1'b1;
                  state <= tty_command;
               end
            end

            tty_command: begin
               if (data == code_at) begin
                  busy  <= 1'b0;
                  state <= tty_at_row;
               end else begin
                  scr_wr.we   <= 1'b1;
                  scr_wr.addr <= cursor;
                  scr_wr.data <= data;
                  state       <= tty_put;
               end
            end

            // --------------------
            // Position bytes, taken as they come
            tty_at_row: begin
               if (chr_we) begin
                  row   <= chr[4:0];
                  state <= tty_at_col;
               end
            end

            tty_at_col: begin
               if (chr_we) begin
                  cursor <= {row, chr[4:0]};
                  state  <= tty_idle;
               end
            end

            tty_put: begin
               scr_wr.we <= 1'b0;
               busy      <= 1'b0;
               cursor    <= cursor + 10'd1;   // column carries into row
               state     <= tty_idle;
            end

            default: state <= tty_idle;
         endcase
      end
   end

endmodule

//--- status_console.sv
module status_console import status_console_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    vga,
   input  logic    ntsc,
   input  dna_t    dna,
   input  logic    mem_progress,
   input  logic    mem_ok,
   input  joy_t    joy,
   output scr_wr_t scr_wr
);

   rom_addr_t rom_addr;
   char_t     rom_data;
   char_t     chr;
   logic      chr_we;
   logic      busy;

   status_sequencer u_seq (
      .clk          (clk),
      .rst          (rst),
      .vga          (vga),
      .ntsc         (ntsc),
      .dna          (dna),
      .mem_progress (mem_progress),
      .mem_ok       (mem_ok),
      .joy          (joy),
      .rom_addr     (rom_addr),
      .rom_data     (rom_data),
      .chr          (chr),
      .chr_we       (chr_we),
      .busy         (busy)
   );

   message_rom u_rom (
      .clk      (clk),
      .rom_addr (rom_addr),
      .rom_data (rom_data)
   );

   teletype u_tty (
      .clk    (clk),
      .rst    (rst),
      .chr    (chr),
      .chr_we (chr_we),
      .busy   (busy),
      .scr_wr (scr_wr)
   );

endmodule

//--- status_console_props.sv
module status_console_props import status_console_pkg::*; (
   input logic    clk,
   input logic    rst,
   input logic    busy,
   input scr_wr_t scr_wr
);

   // One write per accepted character
   a_we_single: assert property (@(posedge clk) disable iff (rst)
      scr_wr.we |=> !scr_wr.we)
      else $error("scr_wr.we high on two cycles in a row");

   a_we_busy: assert property (@(posedge clk) disable iff (rst)
      scr_wr.we |-> busy)
      else $error("screen write while busy is low");

   a_row_range: assert property (@(posedge clk) disable iff (rst)
      scr_wr.we |-> scr_wr.addr[9:5] < 5'(scr_rows))
      else $error("screen write to row %0d", scr_wr.addr[9:5]);

endmodule

bind teletype status_console_props u_props (
   .clk    (clk),
   .rst    (rst),
   .busy   (busy),
   .scr_wr (scr_wr)
);

//--- tb_status_console.sv
module tb_status_console import status_console_pkg::*; ();

   localparam int n_phases        = 10;
   localparam int phase_cycles    = 3000;
   localparam int watchdog_cycles = (n_phases + 1) * phase_cycles;   // one phase of slack

   localparam logic [127:0] hex_digits  = "0123456789ABCDEF";
   localparam logic [63:0]  joy_letters = "UDLR123S";
   localparam logic [31:0]  word_vga    = "VGA ";
   localparam logic [31:0]  word_pal    = "PAL ";
   localparam logic [31:0]  word_ntsc   = "NTSC";
   localparam logic [39:0]  word_wait   = "wait ";
   localparam logic [39:0]  word_ok     = "OK   ";
   localparam logic [39:0]  word_error  = "ERROR";

   logic    clk = 1'b0;
   logic    rst;
   logic    vga;
   logic    ntsc;
   dna_t    dna;
   logic    mem_progress;
   logic    mem_ok;
   joy_t    joy;
   scr_wr_t scr_wr;

   char_t       screen [0:1023];   // Screen model
   logic [31:0] lfsr = 32'hd49c;
   int          reset_errors  = 0;
   int          stray_writes  = 0;
   int          cell_errors   = 0;
   int          cells_checked = 0;
   event        check_ev;

   status_console uut (
      .clk          (clk),
      .rst          (rst),
      .vga          (vga),
      .ntsc         (ntsc),
      .dna          (dna),
      .mem_progress (mem_progress),
      .mem_ok       (mem_ok),
      .joy          (joy),
      .scr_wr       (scr_wr)
   );

   always #10 clk = ~clk;

   // --------------------
   // Random source, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[62:0], lfsr[0]};
      end
   endtask

   // Never-written cells hold a value no character write can produce
   function automatic char_t blank_cell(input scr_addr_t a);
      return {1'b1, a[6:0] ^ {4'b0000, a[9:7]}};
   endfunction

   function automatic bit in_report(input scr_addr_t a);
      int row;
      int col;
      row = int'(a[9:5]);
      col = int'(a[4:0]);
      return (row == 3 && col >= 10 && col <= 13) ||
             (row == 4 && col >= 10 && col <= 24) ||
             (row == 6 && col >= 21 && col <= 25) ||
             (row == 7 && col >= 21 && col <= 28);
   endfunction

   // --------------------
   // Expected screen contents
   function automatic char_t expected_cell(input scr_addr_t a, input logic v, input logic n,
                                           input dna_t d, input logic mp, input logic mo,
                                           input joy_t j);
      int          row;
      int          col;
      int          k;
      logic [31:0] mode_word;
      logic [39:0] mem_word;
      logic [59:0] digits;
      row       = int'(a[9:5]);
      col       = int'(a[4:0]);
      mode_word = v ? word_vga : (n ? word_ntsc : word_pal);
      mem_word  = mp ? word_wait : (mo ? word_ok : word_error);
      digits    = {3'b000, d};
      if (row == 3 && col >= 10 && col <= 13) begin
         k = col - 10;
         return mode_word[8 * (3 - k) +: 8];
      end else if (row == 4 && col >= 10 && col <= 24) begin
         k = col - 10;   // most significant digit first
         return hex_digits[8 * (15 - int'(digits[59 - 4 * k -: 4])) +: 8];
      end else if (row == 6 && col >= 21 && col <= 25) begin
         k = col - 21;
         return mem_word[8 * (4 - k) +: 8];
      end else if (row == 7 && col >= 21 && col <= 28) begin
         k = col - 21;
         return j[7 - k] ? joy_letters[8 * (7 - k) +: 8] : 8'h20;
      end
      return blank_cell(a);
   endfunction

   task automatic check_we_low(input string when);
      if (scr_wr.we !== 1'b0) begin
         reset_errors++;
         $display("ERR scr_wr.we %s: got %h, expected 0", when, scr_wr.we);
      end
   endtask

   task automatic apply_phase(input int p);
      logic [63:0] bits;
      if (p == 0) begin
         dna <= '1;
         joy <= '1;
      end else if (p == 1) begin
         dna <= '0;
         joy <= '0;
      end else begin
         draw_bits(57, bits);
         dna <= bits[56:0];
         draw_bits(8, bits);
         joy <= bits[7:0];
      end
      vga          <= (p % 4 == 0) || (p % 4 == 3);
      ntsc         <= (p % 4 >= 2);
      mem_progress <= (p % 3 == 0);
      mem_ok       <= (p % 3 == 1) || (p % 6 == 3);   // wait with ok set too
   endtask

   // --------------------
   // Screen model
   initial begin : screen_model
      for (int a = 0; a < 1024; a++)
         screen[a] = blank_cell(scr_addr_t'(a));
      forever begin
         @(posedge clk);
         if (!rst && scr_wr.we) begin
            if (!in_report(scr_wr.addr)) begin
               stray_writes++;
               $display("Write of %02h to row %0d col %0d lies outside the report lines",
                        scr_wr.data, scr_wr.addr[9:5], scr_wr.addr[4:0]);
            end
            screen[scr_wr.addr] = scr_wr.data;
         end
      end
   end

   always @(check_ev) begin : compare
      char_t exp;
      for (int a = 0; a < 1024; a++) begin
         exp = expected_cell(scr_addr_t'(a), vga, ntsc, dna, mem_progress, mem_ok, joy);
         cells_checked++;
         if (screen[a] !== exp) begin
            cell_errors++;
            $display("ERR scr_wr.data at %03h (row %0d col %0d): got %02h, expected %02h",
                     a, a / 32, a % 32, screen[a], exp);
         end
      end
   end

   initial begin : watchdog
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
      $display("STATUS: FAIL");
      $finish;
   end

   // --------------------
   // Main sequence
   initial begin : main
      rst          = 1'b1;
      vga          = 1'b0;
      ntsc         = 1'b0;
      dna          = '0;
      mem_progress = 1'b0;
      mem_ok       = 1'b0;
      joy          = '0;

      @(posedge clk);
      @(negedge clk);
      check_we_low("in reset");
      @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_we_low("in reset");
      @(posedge clk);
      @(negedge clk);
      check_we_low("first cycle after reset");

      for (int p = 0; p < n_phases; p++) begin
         @(posedge clk);
         apply_phase(p);
         repeat (phase_cycles) @(posedge clk);
         @(negedge clk);   // model settled
         -> check_ev;
      end
      @(posedge clk);

      $display("Reset errors %0d, stray writes %0d, cell mismatches %0d of %0d cells checked",
               reset_errors, stray_writes, cell_errors, cells_checked);
      if (reset_errors + stray_writes + cell_errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- status_console.f
status_console_pkg.sv
message_rom.sv
status_sequencer.sv
teletype.sv
status_console.sv
status_console_props.sv
tb_status_console.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module tb_status_console -f status_console.f

./obj_dir/Vtb_status_console > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"
